//--- build.f
design/maze_pkg.sv
design/net_table.sv
design/map_store.sv
design/lee_wavefront.sv
design/route_retrace.sv
design/route_ctrl.sv
design/row_credit_out.sv
design/maze_router.sv
dv/tb_maze_router.sv

//--- design/lee_wavefront.sv
// location rows are taken from the first GRID of every 2*GRID map beats
// an unreachable sink leaves the ripple running forever
`timescale 1ns/1ps

module lee_wavefront import maze_pkg::*; #(
	parameter int GRID = 8
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    map_valid,
	input  map_row_t                map_word,
	input  route_state_t            state,
	input  net_pair_t               cur_net,
	input  logic                    wr_en,
	input  coord_t                  wr_pos,
	output logic [2*GRID*GRID-1:0]  marks,
	output logic                    sink_reached,
	output logic [1:0]              phase
);

	localparam int CW = $clog2(GRID);

	mark_t              m [GRID][GRID];
	logic [CW:0]        ld_cnt;
	logic [1:0]         pc;
	mark_t              wave_mark;
	// wave bits with a zero border so edge cells need no bounds test
	logic [GRID+1:0][GRID+1:0] wave_pad;

	assign wave_mark    = mark_t'({1'b1, pc[1]});
	assign sink_reached = m[cur_net.snk.row][cur_net.snk.col][1];
	assign phase        = pc;

	always_comb begin
		wave_pad = '0;
		for (int r = 0; r < GRID; r++) begin
			for (int c = 0; c < GRID; c++) begin
				wave_pad[r+1][c+1] = m[r][c][1];
				marks[2*(r*GRID + c) +: 2] = m[r][c];
			end
		end
	end

	// load row count wraps every 2*GRID beats, path count
	// goes up per wave step and down per path write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_cnt <= '0;
			pc     <= '0;
		end else begin
			if (map_valid)
				ld_cnt <= ld_cnt + 1'b1;
			if (state == st_ripple_init)
				pc <= '0;
			else if (state == st_ripple && !sink_reached)
				pc <= pc + 1'b1;
			else if (wr_en)
				pc <= pc - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (map_valid && !ld_cnt[CW]) begin
			// any net id in the location map is an obstacle
			for (int c = 0; c < GRID; c++) begin
				m[ld_cnt[CW-1:0]][c] <= (map_word[c] != '0) ? mark_blocked : mark_empty;
			end
		end else begin
			case (state)
				// sink pin is blocked from load, open it for the wave
				st_ripple_init: m[cur_net.snk.row][cur_net.snk.col] <= mark_empty;
				st_ripple: begin
					if (!sink_reached) begin
						for (int r = 0; r < GRID; r++) begin
							for (int c = 0; c < GRID; c++) begin
								if (m[r][c] == mark_empty &&
								    (wave_pad[r][c+1] || wave_pad[r+2][c+1] ||
								     wave_pad[r+1][c] || wave_pad[r+1][c+2]))
									m[r][c] <= wave_mark;
							end
						end
						// seed on the first step, rewrite on wrap keeps the same phase
						if (pc == 2'd0)
							m[cur_net.src.row][cur_net.src.col] <= wave_mark;
					end
				end
				// sink becomes part of the routed net
				st_retrace_first: m[cur_net.snk.row][cur_net.snk.col] <= mark_blocked;
				st_retrace: begin
					if (wr_en)
						m[wr_pos.row][wr_pos.col] <= mark_blocked;
				end
				st_next_net: begin
					for (int r = 0; r < GRID; r++) begin
						for (int c = 0; c < GRID; c++) begin
							if (m[r][c][1])
								m[r][c] <= mark_empty;
						end
					end
				end
				default: ;
			endcase
		end
	end

endmodule

//--- design/map_store.sv
// expects exactly 2*GRID words per frame, location rows first then weight rows
`timescale 1ns/1ps

module map_store import maze_pkg::*; #(
	parameter int GRID = 8
) (
	input  logic               clk,
	input  logic               map_valid,
	input  map_row_t           map_word,
	input  logic               wr_en,
	input  coord_t             wr_pos,
	input  cell_t              wr_id,
	input  coord_t             rd_pos,
	input  logic [COORD_W-1:0] row_sel,
	output cell_t              weight,
	output map_row_t           row
);

	// ------------------------------
	// row array
	// ------------------------------
	// entries 0..GRID-1 hold location rows, GRID..2*GRID-1 weight rows
	map_row_t rows [2*GRID];

	// words enter at the top and move down one entry per beat,
	// after the last beat location row 0 lands in entry 0
	always_ff @(posedge clk) begin
		if (map_valid) begin
			for (int i = 0; i < 2*GRID - 1; i++) begin
				rows[i] <= rows[i+1];
			end
			rows[2*GRID-1] <= map_word;
		end else if (wr_en) begin
			// path cell takes the net id
			rows[wr_pos.row][wr_pos.col] <= wr_id;
		end
	end

	// ------------------------------
	// read side
	// ------------------------------
	// weight of the cell under retrace
	assign weight = rows[GRID + rd_pos.row][rd_pos.col];

	// routed location row for readout
	assign row = rows[row_sel];

endmodule

//--- design/maze_pkg.sv
// grid size, net id width and cost width for the maze router
// types are built from the defaults here; module parameters must match them
package maze_pkg;

	// grid geometry
	localparam int GRID    = 8;
	localparam int COORD_W = $clog2(GRID);
	localparam int NET_W   = 4;
	localparam int MAX_NETS = 7;
	localparam int COST_W  = 10;

	// one nibble of a map row, net id or weight
	typedef logic [NET_W-1:0] cell_t;
	// cell 0 sits in the low nibble
	typedef cell_t [GRID-1:0] map_row_t;

	typedef struct packed {
		logic [COORD_W-1:0] row;
		logic [COORD_W-1:0] col;
	} coord_t;

	// input pin record
	typedef struct packed {
		logic [NET_W-1:0] id;
		coord_t           pos;
	} net_t;

	// one captured net, source and sink
	typedef struct packed {
		logic [NET_W-1:0] id;
		coord_t           src;
		coord_t           snk;
	} net_pair_t;

	// high bit marks a wave cell, low bit is the path-count phase
	typedef enum logic [1:0] {
		mark_empty   = 2'b00,
		mark_blocked = 2'b01,
		mark_wave_a  = 2'b10,
		mark_wave_b  = 2'b11
	} mark_t;

	typedef enum logic [2:0] {
		st_idle, st_load, st_ripple_init, st_ripple,
		st_retrace_first, st_retrace, st_next_net, st_readout
	} route_state_t;

endpackage

//--- design/maze_router.sv
// single-frame Lee maze router; GRID must match the package default
`timescale 1ns/1ps

module maze_router import maze_pkg::*; #(
	parameter int GRID     = 8,
	parameter int MAX_NETS = 7
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              map_valid,
	input  map_row_t          map_word,
	input  logic              in_valid,
	input  net_t              pin,
	output logic              busy,
	output logic [COST_W-1:0] cost,
	output logic              out_valid,
	output map_row_t          out_row,
	input  logic              out_credit
);

	route_state_t           state;
	net_pair_t              cur_net;
	logic                   last_net;
	logic [2*GRID*GRID-1:0] marks;
	logic                   sink_reached;
	logic [1:0]             phase;
	logic                   wr_en;
	coord_t                 wr_pos;
	logic                   at_source;
	cell_t                  weight;
	map_row_t               row;
	logic [COORD_W-1:0]     row_sel;
	logic                   rows_done;

	route_ctrl route_ctrl_i (
		.clk, .rst_n, .in_valid, .sink_reached, .at_source, .last_net, .rows_done,
		.state, .busy
	);

	net_table #(.MAX_NETS(MAX_NETS)) net_table_i (
		.clk, .rst_n, .in_valid, .pin, .state, .cur_net, .last_net
	);

	// retrace position serves both the weight read and the path write
	map_store #(.GRID(GRID)) map_store_i (
		.clk, .map_valid, .map_word, .wr_en, .wr_pos, .wr_id(cur_net.id),
		.rd_pos(wr_pos), .row_sel, .weight, .row
	);

	lee_wavefront #(.GRID(GRID)) lee_wavefront_i (
		.clk, .rst_n, .map_valid, .map_word, .state, .cur_net, .wr_en, .wr_pos,
		.marks, .sink_reached, .phase
	);

	route_retrace #(.GRID(GRID)) route_retrace_i (
		.clk, .rst_n, .state, .cur_net, .marks, .phase, .weight,
		.wr_en, .wr_pos, .at_source, .cost
	);

	row_credit_out #(.GRID(GRID)) row_credit_out_i (
		.clk, .rst_n, .state, .row, .out_credit,
		.row_sel, .out_valid, .out_row, .rows_done
	);

endmodule

//--- design/net_table.sv
// pins must alternate source then sink; more than MAX_NETS nets is not handled
`timescale 1ns/1ps

module net_table import maze_pkg::*; #(
	parameter int MAX_NETS = 7
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  net_t         pin,
	input  route_state_t state,
	output net_pair_t    cur_net,
	output logic         last_net
);

	localparam int IDX_W = $clog2(MAX_NETS + 1);

	net_pair_t        pairs [MAX_NETS];
	logic [IDX_W-1:0] net_cnt;
	logic [IDX_W-1:0] cur_idx;
	// high when the next beat is a sink
	logic             snk_beat;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snk_beat <= 1'b0;
			net_cnt  <= '0;
			cur_idx  <= '0;
		end else if (state == st_readout) begin
			// frame finished, ready for the next pin list
			snk_beat <= 1'b0;
			net_cnt  <= '0;
			cur_idx  <= '0;
		end else begin
			if (in_valid) begin
				snk_beat <= ~snk_beat;
				// a pair is complete on its sink beat
				if (snk_beat)
					net_cnt <= net_cnt + 1'b1;
			end
			if (state == st_next_net)
				cur_idx <= cur_idx + 1'b1;
		end
	end

	// pin storage, id comes from the source beat
	always_ff @(posedge clk) begin
		if (in_valid && !snk_beat) begin
			pairs[net_cnt].id  <= pin.id;
			pairs[net_cnt].src <= pin.pos;
		end
		if (in_valid && snk_beat)
			pairs[net_cnt].snk <= pin.pos;
	end

	assign cur_net  = pairs[cur_idx];
	assign last_net = (cur_idx + 1'b1 == net_cnt);

endmodule

//--- design/route_ctrl.sv
// map words must arrive before the first pin; a gap in the pin burst starts routing
`timescale 1ns/1ps

module route_ctrl import maze_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         in_valid,
	input  logic         sink_reached,
	input  logic         at_source,
	input  logic         last_net,
	input  logic         rows_done,
	output route_state_t state,
	output logic         busy
);

	route_state_t state_nxt;
	logic         in_valid_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= st_idle;
			in_valid_d <= 1'b0;
		end else begin
			state      <= state_nxt;
			in_valid_d <= in_valid;
		end
	end

	// ------------------------------
	// next state
	// ------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (in_valid)
					state_nxt = st_load;
			end
			// falling edge of the pin stream
			st_load: begin
				if (in_valid_d && !in_valid)
					state_nxt = st_ripple_init;
			end
			st_ripple_init: state_nxt = st_ripple;
			st_ripple: begin
				if (sink_reached)
					state_nxt = st_retrace_first;
			end
			st_retrace_first: state_nxt = st_retrace;
			st_retrace: begin
				if (at_source)
					state_nxt = last_net ? st_readout : st_next_net;
			end
			st_next_net: state_nxt = st_ripple_init;
			st_readout: begin
				if (rows_done)
					state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	// high from the cycle after the first pin until readout ends
	assign busy = (state != st_idle);

endmodule

//--- design/route_retrace.sv
// one path cell per read/write pair; cost wraps past 2**COST_W-1
`timescale 1ns/1ps

module route_retrace import maze_pkg::*; #(
	parameter int GRID = 8
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  route_state_t           state,
	input  net_pair_t              cur_net,
	input  logic [2*GRID*GRID-1:0] marks,
	input  logic [1:0]             phase,
	input  cell_t                  weight,
	output logic                   wr_en,
	output coord_t                 wr_pos,
	output logic                   at_source,
	output logic [COST_W-1:0]      cost
);

	coord_t     pos;
	coord_t     nxt;
	logic       wr_cyc;
	logic [1:0] prev_ph;
	mark_t      exp_mark;

	function automatic mark_t mark_at(input logic [COORD_W-1:0] r, input logic [COORD_W-1:0] c);
		return mark_t'(marks[2*(r*GRID + c) +: 2]);
	endfunction

	// wave count runs one past the current cell, the step back is two below
	assign prev_ph  = phase - 2'd2;
	assign exp_mark = mark_t'({1'b1, prev_ph[1]});

	// ------------------------------
	// step choice
	// ------------------------------
	// down, up, right, then left as the fallback
	always_comb begin
		nxt = pos;
		if (pos.row != COORD_W'(GRID-1) && mark_at(pos.row + 1'b1, pos.col) == exp_mark)
			nxt.row = pos.row + 1'b1;
		else if (pos.row != '0 && mark_at(pos.row - 1'b1, pos.col) == exp_mark)
			nxt.row = pos.row - 1'b1;
		else if (pos.col != COORD_W'(GRID-1) && mark_at(pos.row, pos.col + 1'b1) == exp_mark)
			nxt.col = pos.col + 1'b1;
		else
			nxt.col = pos.col - 1'b1;
	end

	// parked on the sink while the wave grows
	always_ff @(posedge clk) begin
		if (state == st_ripple)
			pos <= cur_net.snk;
		else if (state == st_retrace_first || (state == st_retrace && !wr_cyc))
			pos <= nxt;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_cyc <= 1'b0;
			cost   <= '0;
		end else begin
			// first move happens in retrace_first, so retrace opens on a write
			wr_cyc <= (state == st_retrace_first) || (state == st_retrace && !wr_cyc);
			if (state == st_load)
				cost <= '0;
			else if (wr_en)
				cost <= cost + COST_W'(weight);
		end
	end

	assign wr_en     = (state == st_retrace) && wr_cyc;
	assign wr_pos    = pos;
	assign at_source = wr_en && (pos == cur_net.src);

endmodule

//--- design/row_credit_out.sv
// starts with two credits; returning more credits than rows sent is not handled
`timescale 1ns/1ps

module row_credit_out import maze_pkg::*; #(
	parameter int GRID = 8
) (
	input  logic               clk,
	input  logic               rst_n,
	input  route_state_t       state,
	input  map_row_t           row,
	input  logic               out_credit,
	output logic [COORD_W-1:0] row_sel,
	output logic               out_valid,
	output map_row_t           out_row,
	output logic               rows_done
);

	localparam int OUT_CREDITS = 2;
	localparam int CRW = $clog2(OUT_CREDITS + 1);

	logic [CRW-1:0] credits;

	// one row per cycle while any credit is left
	assign out_valid = (state == st_readout) && (credits != '0);
	assign out_row   = row;
	assign rows_done = out_valid && (row_sel == COORD_W'(GRID-1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= CRW'(OUT_CREDITS);
			row_sel <= '0;
		end else begin
			// spend and return can land in the same cycle
			credits <= credits - CRW'(out_valid) + CRW'(out_credit);
			if (out_valid)
				row_sel <= rows_done ? '0 : row_sel + 1'b1;
		end
	end

endmodule

//--- dv/tb_maze_router.sv
// runs two frames from dv/testdata_maze.hex; run from the project root
// output credits start at two and are withheld for a while in the first frame
`timescale 1ns/1ps

module tb_maze_router import maze_pkg::*;;

	localparam int OUT_CREDITS = 2;
	localparam int HOLD_CYCLES = 16;

	logic              clk;
	logic              rst_n;
	logic              map_valid;
	map_row_t          map_word;
	logic              in_valid;
	net_t              pin;
	logic              busy;
	logic [COST_W-1:0] cost;
	logic              out_valid;
	map_row_t          out_row;
	logic              out_credit;

	// frame records as laid out in the data file
	logic [31:0] mem [0:63];
	int          errors;
	int          checks;
	bit          timed_out;
	int          seed;
	// credit bookkeeping shared with the credit return process
	int          rows_seen;
	int          credits_back;
	bit          hold_credits;

	maze_router #(.GRID(GRID), .MAX_NETS(MAX_NETS)) maze_router_i (
		.clk, .rst_n, .map_valid, .map_word, .in_valid, .pin,
		.busy, .cost, .out_valid, .out_row, .out_credit
	);

	always #2 clk = ~clk;

	// ------------------------------
	// credit return
	// ------------------------------
	// one credit back per received row after a random gap and none while held
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (!hold_credits && credits_back < rows_seen && ($random(seed) & 1)) begin
				out_credit = 1'b1;
				credits_back++;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// location rows then weight rows then pins back to back
	task automatic send_inputs(input int base);
		int n;
		n = mem[base];
		for (int i = 0; i < 2*GRID; i++) begin
			@(posedge clk);
			#1;
			map_valid = 1'b1;
			map_word  = map_row_t'(mem[base + 1 + i]);
		end
		for (int k = 0; k < n; k++) begin
			@(posedge clk);
			#1;
			map_valid = 1'b0;
			in_valid  = 1'b1;
			pin       = net_t'(mem[base + 1 + 2*GRID + k][9:0]);
			@(negedge clk);
			// busy follows the first pin by one cycle
			check_value("busy", busy, (k == 0) ? 1'b0 : 1'b1);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		@(negedge clk);
		// cost restarts from zero in load
		check_value("cost", cost, '0);
	endtask

	task automatic collect_rows(input int base, input bit hold);
		int n;
		int got;
		int cyc;
		int quiet;
		logic [31:0] exp_row;
		n = mem[base];
		got = 0;
		cyc = 0;
		quiet = 0;
		// wait for the first row, busy holds through routing
		while (!out_valid && cyc < 4000) begin
			check_value("busy", busy, 1'b1);
			@(negedge clk);
			cyc++;
		end
		if (!out_valid) begin
			timed_out = 1'b1;
			$display("timeout waiting for the first routed row");
			return;
		end
		check_value("cost", cost, mem[base + 1 + 2*GRID + n]);
		hold_credits = hold;
		cyc = 0;
		while (got < GRID && cyc < 2000) begin
			// busy holds through readout stalls too
			check_value("busy", busy, 1'b1);
			if (out_valid) begin
				if (hold_credits && got >= OUT_CREDITS) begin
					errors++;
					$display("a row was sent with no credit left");
				end
				exp_row = mem[base + 2 + 2*GRID + n + got];
				checks++;
				if (out_row !== exp_row) begin
					errors++;
					$display("ERROR out_row[%0d] got %h expected %h", got, out_row, exp_row);
				end
				got++;
				rows_seen++;
			end else if (hold_credits && got >= OUT_CREDITS) begin
				// stream must stay stopped until credits come back
				quiet++;
				if (quiet == HOLD_CYCLES)
					hold_credits = 1'b0;
			end
			@(negedge clk);
			cyc++;
		end
		if (got < GRID) begin
			timed_out = 1'b1;
			$display("timeout with only %0d of %0d rows received", got, GRID);
			return;
		end
		// cycle after the last row
		check_value("busy", busy, 1'b0);
		check_value("out_valid", out_valid, 1'b0);
	endtask

	task automatic run_frame(input int base, input bit hold);
		if (timed_out)
			return;
		send_inputs(base);
		collect_rows(base, hold);
	endtask

	initial begin
		int base;
		clk          = 1'b0;
		rst_n        = 1'b0;
		map_valid    = 1'b0;
		map_word     = '0;
		in_valid     = 1'b0;
		pin          = '0;
		out_credit   = 1'b0;
		errors       = 0;
		checks       = 0;
		timed_out    = 1'b0;
		seed         = 32'h29b3_8393;
		rows_seen    = 0;
		credits_back = 0;
		hold_credits = 1'b0;
		$readmemh("dv/testdata_maze.hex", mem);

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("busy", busy, 1'b0);
		check_value("out_valid", out_valid, 1'b0);

		// first frame withholds credits and the second runs after idle
		base = 0;
		run_frame(base, 1'b1);
		base = base + 2 + 3*GRID + mem[base];
		run_frame(base, 1'b0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- dv/testdata_maze.hex
// per frame: pin count, 8 location rows, 8 weight rows, pins {id,row,col},
// expected cost, 8 expected routed rows; cell 0 is the low nibble
// frame 1, two nets, obstacle F at row 2 col 3
00000004
00000000
00020000
0010F010
00000000
00020000
00000000
00000000
00000000
// weights are row plus column
76543210
87654321
98765432
A9876543
BA987654
CBA98765
DCBA9876
EDCBA987
// net 1 (2,1)->(2,5), net 2 (4,4)->(1,4)
00000051
00000055
000000A4
0000008C
0000005A
00000000
02220000
0210F110
02111100
02220000
00000000
00000000
00000000
// frame 2, net 3 (6,0)->(6,3), net 4 (0,6)->(2,7)
00000004
04000000
00000000
40000000
00000000
00000000
00000000
00003003
00000000
76543210
87654321
98765432
A9876543
BA987654
CBA98765
DCBA9876
EDCBA987
000000F0
000000F3
00000106
00000117
0000002A
44000000
40000000
40000000
00000000
00000000
00000000
00003333
00000000
